// File: logic/zxuno_pkg.sv
package zxuno_pkg;

   ////////////////////
   // I/O port map
   ////////////////////
   // Low address byte of each native port
   localparam logic [7:0] port_spi_data = 8'hEB;  // Shared by flash and SD
   localparam logic [7:0] port_spi_cs   = 8'hE7;  // Chip selects
   localparam logic [7:0] port_kempston = 8'h1F;  // Joystick
   localparam logic [7:0] port_ula      = 8'hFE;  // Speaker and mic out plus ear in

   // Bit positions in the port bytes
   localparam int cs_flash_bit = 0;  // Flash select in 0xE7
   localparam int cs_sd_bit    = 1;  // SD select in 0xE7
   localparam int ula_mic_bit  = 3;  // Mic in 0xFE writes
   localparam int ula_spk_bit  = 4;  // Speaker in 0xFE writes
   localparam int ula_ear_bit  = 6;  // Ear in 0xFE reads

   // Read values
   localparam logic [7:0] bus_float     = 8'hFF;  // Nobody drives the bus
   localparam logic [7:0] ula_read_base = 8'hBF;  // 0xFE read with the ear bit cleared

   ////////////////////
   // Audio mixing
   ////////////////////
   // Pulse density weights for the DAC
   localparam logic [7:0] lvl_speaker = 8'h80;
   localparam logic [7:0] lvl_mic     = 8'h20;
   localparam logic [7:0] lvl_ear     = 8'h18;
   // All three together give 0xB8 so the sum never wraps

   ////////////////////
   // SPI
   ////////////////////
   localparam int         spi_bits      = 8;                // Bits per transfer
   localparam int         spi_cnt_w     = $clog2(spi_bits); // Bit counter width
   localparam logic [7:0] spi_idle_byte = 8'hFF;            // Sent when a read launches

   // Kempston joystick as read on port 0x1F
   // Field order gives fire in bit 4 down to right in bit 0
   typedef struct packed {
      logic fire;
      logic up;
      logic down;
      logic left;
      logic right;
   } kempston_t;

endpackage

// File: logic/spi_bus_if.sv
`timescale 1ns/1ps

// Link between the port controller and the SPI byte shifter
interface spi_bus_if;
   logic       start;    // One-cycle request
   logic [7:0] tx_byte;  // Byte to send, sampled with start
   logic [7:0] rx_byte;  // Last byte received
   logic       busy;     // Start seen until done
   logic       done;     // One-cycle pulse, rx_byte valid

   modport ctrl (
      output start,
      output tx_byte,
      input  rx_byte,
      input  busy,
      input  done
   );

   modport shifter (
      input  start,
      input  tx_byte,
      output rx_byte,
      output busy,
      output done
   );
endinterface

// File: logic/input_sync.sv
`timescale 1ns/1ps

// Two-flop synchronizer for slow board inputs
// Works for single bits and packed structs alike
module input_sync #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic rst_n,
   input  T     async_in,
   output T     sync_out
);

   T meta;   // First stage, may go metastable

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meta     <= '0;
         sync_out <= '0;
      end else begin
         meta     <= async_in;
         sync_out <= meta;     // Two cycles of latency
      end
   end

endmodule

// File: logic/sigma_delta_dac.sv
`timescale 1ns/1ps

// First order sigma-delta modulator
// One bit out per clock, density of ones is level/256
module sigma_delta_dac (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] level,
   output logic       audio
);

   // Low 8 bits hold the error
   // Bit 8 is the carry of the last add
   logic [8:0] acc;
   logic [8:0] acc_next;

   ////////////////////
   // Accumulator
   ////////////////////
   // Error plus input, the old carry is dropped
   assign acc_next = {1'b0, acc[7:0]} + {1'b0, level};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         acc <= '0;
      else
         acc <= acc_next;   // Update every cycle
   end

   // Carry out is the stream
   // For a steady level the error returns to its start after 256 adds
   // so each 256-cycle window holds exactly level ones
   assign audio = acc[8];

   // Level 0 never carries and gives a flat low line
   // Level 0xFF misses one pulse in 256

endmodule

// File: logic/spi_byte_shifter.sv
`timescale 1ns/1ps

// Mode 0 SPI master, MSB first, SCLK at half the system clock
module spi_byte_shifter (
   input  logic       clk,
   input  logic       rst_n,
   spi_bus_if.shifter spi,
   output logic       sclk,
   output logic       mosi,
   input  logic       miso
);
   import zxuno_pkg::*;

   logic [spi_bits-1:0]  shreg;     // Out on top, in at the bottom
   logic [spi_cnt_w-1:0] bit_cnt;
   logic                 miso_q;    // Bit caught on the rising SCLK
   logic                 last_bit;

   assign last_bit = (bit_cnt == spi_cnt_w'(spi_bits - 1));

   // Line idles high between transfers
   assign mosi = spi.busy ? shreg[spi_bits-1] : 1'b1;

   ////////////////////
   // Sequencing
   ////////////////////
   // Start seen: load and wait one cycle for MOSI to settle
   // Then SCLK rises and falls on alternate cycles, 8 times
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         spi.busy <= 1'b0;
         spi.done <= 1'b0;
         sclk     <= 1'b0;
         bit_cnt  <= '0;
      end else begin
         spi.done <= 1'b0;             // Pulse
         if (!spi.busy) begin
            if (spi.start) begin
               spi.busy <= 1'b1;
               bit_cnt  <= '0;
            end
         end else if (!sclk) begin
            sclk <= 1'b1;              // Rising edge, both sides sample
         end else begin
            sclk    <= 1'b0;           // Falling edge, both sides shift
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
               spi.busy <= 1'b0;
               spi.done <= 1'b1;      // 17 cycles after start
            end
         end
      end
   end

   ////////////////////
   // Data path
   ////////////////////
   always_ff @(posedge clk) begin
      if (!spi.busy && spi.start) begin
         shreg <= spi.tx_byte;
      end else if (spi.busy && !sclk) begin
         miso_q <= miso;               // Slave set it on the last falling edge
      end else if (spi.busy && sclk) begin
         shreg <= {shreg[spi_bits-2:0], miso_q};
         if (last_bit)
            spi.rx_byte <= {shreg[spi_bits-2:0], miso_q};  // Held until next done
      end
   end

endmodule

// File: logic/io_port_ctrl.sv
`timescale 1ns/1ps

module io_port_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [7:0]           addr,
   input  logic [7:0]           din,
   input  logic                 iorq_wr,
   input  logic                 iorq_rd,
   output logic [7:0]           dout,
   spi_bus_if.ctrl              spi,
   input  logic                 ear,        // Already synchronized
   input  zxuno_pkg::kempston_t joy,        // Already synchronized
   output logic                 flash_cs_n,
   output logic                 sd_cs_n,
   output logic                 testled,
   output logic [7:0]           level
);
   import zxuno_pkg::*;

   logic       sel_spi_data;
   logic       sel_spi_cs;
   logic       sel_kempston;
   logic       sel_ula;
   logic [1:0] cs_reg;      // Active low selects
   logic       spk_reg;
   logic       mic_reg;
   logic       xfer_pend;   // Start sent and done not back yet
   logic       can_start;
   logic       spi_launch;
   logic [7:0] rd_mux;

   // Port decode on the low address byte
   assign sel_spi_data = (addr == port_spi_data);
   assign sel_spi_cs   = (addr == port_spi_cs);
   assign sel_kempston = (addr == port_kempston);
   assign sel_ula      = (addr == port_ula);

   ////////////////////
   // Port registers
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cs_reg  <= 2'b11;  // Both devices released
         spk_reg <= 1'b0;
         mic_reg <= 1'b0;
      end else if (iorq_wr) begin
         if (sel_spi_cs) begin
            // Flash wins if software selects both
            cs_reg[0] <= din[cs_flash_bit];
            cs_reg[1] <= din[cs_sd_bit] | ~din[cs_flash_bit];
         end
         if (sel_ula) begin
            spk_reg <= din[ula_spk_bit];
            mic_reg <= din[ula_mic_bit];
         end
      end
   end

   assign flash_cs_n = cs_reg[0];
   assign sd_cs_n    = cs_reg[1];
   assign testled    = ~flash_cs_n | ~sd_cs_n;  // Lit while any SPI device is selected

   ////////////////////
   // SPI requests
   ////////////////////
   // Shifter drops busy in the same cycle that done is high
   assign can_start  = ~spi.busy & (~xfer_pend | spi.done);
   // Any access to 0xEB launches a byte
   assign spi_launch = can_start & sel_spi_data & (iorq_wr | iorq_rd);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         spi.start <= 1'b0;
         xfer_pend <= 1'b0;
      end else begin
         spi.start <= spi_launch;       // Seen by the shifter one cycle later
         if (spi_launch)
            xfer_pend <= 1'b1;
         else if (spi.done)
            xfer_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (spi_launch)
         spi.tx_byte <= iorq_wr ? din : spi_idle_byte;  // Reads clock out 0xFF
   end

   ////////////////////
   // Read data
   ////////////////////
   always_comb begin
      rd_mux = bus_float;
      if (sel_spi_data) begin
         rd_mux = spi.rx_byte;        // Byte from the previous transfer
      end else if (sel_kempston) begin
         rd_mux = {3'b000, joy};
      end else if (sel_ula) begin
         rd_mux              = ula_read_base;
         rd_mux[ula_ear_bit] = ear;
      end
   end

   // Holds until the next read
   always_ff @(posedge clk) begin
      if (iorq_rd)
         dout <= rd_mux;
   end

   // Audio mix for the DAC
   assign level = (spk_reg ? lvl_speaker : 8'h00)
                + (mic_reg ? lvl_mic : 8'h00)
                + (ear ? lvl_ear : 8'h00);

endmodule

// File: logic/tld_zxuno.sv
`timescale 1ns/1ps

module tld_zxuno (
   // System clock and CPU side I/O bus
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] addr,
   input  logic [7:0] din,
   input  logic       iorq_wr,
   input  logic       iorq_rd,
   output logic [7:0] dout,

   // Tape in and joystick
   input  logic       ear,              // Inverted by the board transistor
   input  logic       joyup,
   input  logic       joydown,
   input  logic       joyleft,
   input  logic       joyright,
   input  logic       joyfire,

   output logic       audio_out_left,
   output logic       audio_out_right,
   output logic       testled,          // SPI activity

   output logic       flash_cs_n,
   output logic       flash_clk,
   output logic       flash_mosi,
   input  logic       flash_miso,

   output logic       sd_cs_n,
   output logic       sd_clk,
   output logic       sd_mosi,
   input  logic       sd_miso
);
   import zxuno_pkg::*;

   spi_bus_if spi_bus ();

   logic       ear_sync;
   kempston_t  joy_raw;
   kempston_t  joy_sync;
   logic [7:0] level;
   logic       audio_out;
   logic       spi_clk;
   logic       spi_mosi;
   logic       spi_miso;

   ////////////////////
   // Board inputs
   ////////////////////
   assign joy_raw = '{fire: joyfire, up: joyup, down: joydown,
                      left: joyleft, right: joyright};

   input_sync #(.T(logic)) ear_sync_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .async_in (~ear),          // Undo the transistor
      .sync_out (ear_sync)
   );

   input_sync #(.T(kempston_t)) joy_sync_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .async_in (joy_raw),
      .sync_out (joy_sync)
   );

   ////////////////////
   // Ports and SPI
   ////////////////////
   io_port_ctrl port_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (addr),
      .din        (din),
      .iorq_wr    (iorq_wr),
      .iorq_rd    (iorq_rd),
      .dout       (dout),
      .spi        (spi_bus.ctrl),
      .ear        (ear_sync),
      .joy        (joy_sync),
      .flash_cs_n (flash_cs_n),
      .sd_cs_n    (sd_cs_n),
      .testled    (testled),
      .level      (level)
   );

   spi_byte_shifter spi_shifter (
      .clk   (clk),
      .rst_n (rst_n),
      .spi   (spi_bus.shifter),
      .sclk  (spi_clk),
      .mosi  (spi_mosi),
      .miso  (spi_miso)
   );

   // One SPI bus for both devices
   assign flash_clk  = spi_clk;
   assign sd_clk     = spi_clk;
   assign flash_mosi = spi_mosi;
   assign sd_mosi    = spi_mosi;
   assign spi_miso   = flash_cs_n ? sd_miso : flash_miso;  // Flash when selected

   ////////////////////
   // Audio
   ////////////////////
   sigma_delta_dac audio_dac (
      .clk   (clk),
      .rst_n (rst_n),
      .level (level),
      .audio (audio_out)
   );

   assign audio_out_left  = audio_out;   // Mono on both channels
   assign audio_out_right = audio_out;

endmodule

// File: sim/tld_zxuno_chk.sv
`timescale 1ns/1ps

// Rules on the top's pins and the SPI link
module tld_zxuno_chk (
   input logic clk,
   input logic rst_n,
   input logic flash_cs_n,
   input logic sd_cs_n,
   input logic testled,
   input logic iorq_wr,
   input logic iorq_rd,
   input logic sclk,
   input logic busy
);
   int unsigned fails = 0;   // Failed assertion count

   ////////////////////
   // SPI bus
   ////////////////////
   cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                                  flash_cs_n || sd_cs_n)
      else begin
         $error("Flash and SD selected together");
         fails++;
      end

   sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
                               !busy |-> !sclk)   // Mode 0 idle level
      else begin
         $error("SPI clock high with no transfer");
         fails++;
      end

   led_follows_cs: assert property (@(posedge clk) disable iff (!rst_n)
                                    testled == (!flash_cs_n || !sd_cs_n))
      else begin
         $error("testled does not match the chip selects");
         fails++;
      end

   // CPU bus
   strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                                       !(iorq_wr && iorq_rd))
      else begin
         $error("Write and read strobes high together");
         fails++;
      end

endmodule

bind tld_zxuno tld_zxuno_chk rule_check (
   .clk        (clk),
   .rst_n      (rst_n),
   .flash_cs_n (flash_cs_n),
   .sd_cs_n    (sd_cs_n),
   .testled    (testled),
   .iorq_wr    (iorq_wr),
   .iorq_rd    (iorq_rd),
   .sclk       (spi_clk),
   .busy       (spi_bus.busy)
);

// File: sim/tb_tld_zxuno.sv
`timescale 1ns/1ps

module tb_tld_zxuno;
   import zxuno_pkg::*;

   localparam realtime clk_period  = 4.0;
   localparam realtime drive_dly   = 1.0;   // Inputs move this long after the edge
   localparam int      rst_cycles  = 10;
   localparam int      spi_timeout = 100;   // Cycles allowed for one SPI byte
   localparam          trace_file  = "sim/zxuno_trace.txt";

   logic       clk, rst_n;
   logic [7:0] addr, din, dout;
   logic       iorq_wr, iorq_rd;
   logic       ear, joyup, joydown, joyleft, joyright, joyfire;
   logic       audio_out_left, audio_out_right, testled;
   logic       flash_cs_n, flash_clk, flash_mosi, flash_miso;
   logic       sd_cs_n, sd_clk, sd_mosi, sd_miso;

   integer     seed;
   int         errors;
   int         trace_lines;
   logic [7:0] tr_op[$];                    // One entry per trace line
   logic [7:0] tr_a[$];
   logic [7:0] tr_b[$];
   logic [7:0] slave_tx;                    // Byte going out on MISO
   logic [7:0] slave_rx;                    // MOSI as the slave saw it
   logic [7:0] slave_exp;
   int         slave_bits;
   logic       slave_clk;                   // Clock pin of the selected device

   tld_zxuno UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   ////////////////////
   // SPI slave model
   ////////////////////
   // Selected device sends the byte, the other one its complement
   task automatic slave_drive;
      if (!flash_cs_n) begin
         flash_miso = slave_tx[7];
         sd_miso    = ~slave_tx[7];
      end else begin
         sd_miso    = slave_tx[7];
         flash_miso = ~slave_tx[7];
      end
   endtask

   // Both clocks idle low whenever the selects change
   assign slave_clk = flash_cs_n ? sd_clk : flash_clk;

   always @(posedge slave_clk) begin
      #drive_dly;
      if (rst_n === 1'b1) begin
         slave_rx = {slave_rx[6:0], flash_cs_n ? sd_mosi : flash_mosi};  // MSB first
         slave_bits++;
      end
   end

   always @(negedge slave_clk) begin
      #drive_dly;
      if (rst_n === 1'b1) begin
         slave_tx = {slave_tx[6:0], 1'b1};   // Next bit for the next rising edge
         slave_drive();
      end
   end

   ////////////////////
   // Bus and trace ops
   ////////////////////
   task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
      @(posedge clk);
      #drive_dly;
      addr    = a;
      din     = d;
      iorq_wr = 1'b1;
      @(posedge clk);
      #drive_dly;
      iorq_wr = 1'b0;                         // Port registers already updated
   endtask

   task automatic bus_read(input logic [7:0] a, input logic [7:0] exp);
      @(posedge clk);
      #drive_dly;
      addr    = a;
      iorq_rd = 1'b1;
      @(posedge clk);
      #drive_dly;
      iorq_rd = 1'b0;
      check_val("dout", dout, exp);           // Registered one cycle after the strobe
   endtask

   // Active low selects, LED lit while either is low
   task automatic check_selects(input logic [7:0] d);
      check_val("flash_cs_n", flash_cs_n, d[0]);
      check_val("sd_cs_n", sd_cs_n, d[1]);
      check_val("testled", testled, !(d[0] && d[1]));
   endtask

   task automatic wait_spi_byte;
      int cycles;
      int gap;
      cycles = 0;
      while (slave_bits < spi_bits && cycles < spi_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (slave_bits < spi_bits) begin
         $display("SPI transfer did not finish within %0d cycles", spi_timeout);
         errors++;
      end else begin
         check_val("mosi byte", slave_rx, slave_exp);
      end
      gap = 20 + ($unsigned($random(seed)) % 21);  // Software poll delay
      repeat (gap) @(posedge clk);
   endtask

   task automatic count_audio(input logic [7:0] exp_l, input logic [7:0] exp_r);
      int ones_l;
      int ones_r;
      ones_l = 0;
      ones_r = 0;
      repeat (2) @(posedge clk);              // New level into the accumulator
      repeat (256) begin
         @(posedge clk);
         #drive_dly;
         ones_l += audio_out_left;
         ones_r += audio_out_right;
      end
      check_val("audio_out_left ones", ones_l, exp_l);
      check_val("audio_out_right ones", ones_r, exp_r);
   endtask

   task automatic run_op(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b);
      case (op)
         "W": begin
            bus_write(a, b);
            if (a == port_spi_cs)
               check_selects(b);
            else if (a == port_spi_data)
               wait_spi_byte();
         end
         "R": begin
            bus_read(a, b);
            if (a == port_spi_data)
               wait_spi_byte();                // Reads launch a byte too
         end
         "S": begin
            slave_tx   = a;
            slave_exp  = b;
            slave_bits = 0;
            slave_drive();                     // Bit 7 ready before the first edge
         end
         "P": begin
            @(posedge clk);
            #drive_dly;
            ear = a[0];
            {joyfire, joyup, joydown, joyleft, joyright} = b[4:0];
            repeat (2) @(posedge clk);         // Synchronizer latency
         end
         "A": count_audio(a, b);
         default: begin
            $display("Unknown trace opcode %c", op);
            errors++;
         end
      endcase
   endtask

   task automatic load_trace;
      integer     fd;
      integer     ch;
      logic [7:0] op, a, b;
      fd = $fopen(trace_file, "r");
      if (fd == 0) begin
         $display("Cannot open trace file %s", trace_file);
         errors++;
      end else begin
         while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
               ch = 0;
               while (ch != "\n" && ch != -1)
                  ch = $fgetc(fd);             // Skip the comment line
            end else if ($fscanf(fd, " %h %h", a, b) == 2) begin
               tr_op.push_back(op);
               tr_a.push_back(a);
               tr_b.push_back(b);
            end else begin
               $display("Trace line with opcode %c is missing its fields", op);
               errors++;
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin : run
      int i;
      seed       = 32'h5f3a_5df6;
      errors     = 0;
      slave_bits = 0;
      addr       = 8'h00;
      din        = 8'h00;
      iorq_wr    = 1'b0;
      iorq_rd    = 1'b0;
      ear        = 1'b1;                       // Pin high means ear low
      {joyfire, joyup, joydown, joyleft, joyright} = 5'b0;
      flash_miso = 1'b1;
      sd_miso    = 1'b1;
      rst_n      = 1'b0;
      load_trace();
      trace_lines = tr_op.size();
      repeat (rst_cycles) @(posedge clk);
      #drive_dly;
      rst_n = 1'b1;
      check_val("flash_cs_n", flash_cs_n, 1'b1);
      check_val("sd_cs_n", sd_cs_n, 1'b1);
      check_val("testled", testled, 1'b0);
      check_val("flash_clk", flash_clk, 1'b0);
      for (i = 0; i < trace_lines; i++)
         run_op(tr_op[i], tr_a[i], tr_b[i]);
      errors += UUT.rule_check.fails;
      $display("Trace lines: %0d  errors: %0d", trace_lines, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Generous budget per trace line
   initial begin : watchdog
      wait (trace_lines > 0);
      #(trace_lines * 400 * clk_period);
      $display("Timed out: trace not done after %0d cycles", trace_lines * 400);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: sim/zxuno_trace.txt
# op a b: W addr data, R addr dout, S miso_byte mosi_byte
# P ear_pin joy (fire up down left right), A left_ones right_ones
R FE BF
A 00 00
W E7 FE
S A5 3C
W EB 3C
S 5A FF
R EB A5
S 00 FF
R EB 5A
W E7 FD
S C3 96
W EB 96
S 00 FF
R EB C3
W E7 FF
P 1 15
R 1F 15
P 0 0A
R 1F 0A
R FE FF
A 18 18
W FE 18
A B8 B8
P 1 00
A A0 A0
W FE 10
A 80 80
W FE 08
A 20 20
W FE 00
A 00 00

// File: zxuno_io.f
logic/zxuno_pkg.sv
logic/spi_bus_if.sv
logic/input_sync.sv
logic/sigma_delta_dac.sv
logic/spi_byte_shifter.sv
logic/io_port_ctrl.sv
logic/tld_zxuno.sv
sim/tld_zxuno_chk.sv
sim/tb_tld_zxuno.sv
